// ==== sources.f ====
+incdir+logic
logic/afu_err_pkg.sv
logic/error_collector.sv
logic/error_control.sv
logic/mmio_regs.sv
logic/mmio_resp_arbiter.sv
logic/afu_err_top.sv
test/tb_clock_gen.sv
test/afu_err_assertions.sv
test/afu_err_tb.sv

// ==== test/afu_err_tb.sv ====
`timescale 1ns/1ps
`include "afu_err_consts.svh"

module afu_err_tb;

	// Cycle budget per test, then the hang limit
	localparam int test_cycles    = 300;
	localparam int num_tests      = 6;
	localparam int margin_cycles  = 500;
	localparam int timeout_cycles = num_tests * test_cycles + margin_cycles;
	// Longest wait for one response
	localparam int wait_limit     = 60;

	logic                  clock;
	logic                  rstn;
	logic [0:`ERR_WIDTH-1] cmd_errors;
	logic [0:`ERR_WIDTH-1] rsp_errors;
	logic [0:`ERR_WIDTH-1] buf_errors;
	logic                  mmio_write;
	logic                  mmio_read;
	logic [1:0]            mmio_addr;
	logic [0:`ERR_WIDTH-1] mmio_wdata;
	logic                  resp_credit_return;
	logic                  resp_valid;
	afu_err_pkg::resp_kind resp_kind;
	logic [0:`ERR_WIDTH-1] resp_data;

	// Model state
	logic [0:`ERR_WIDTH-1] model_sticky;
	logic [0:`ERR_WIDTH-1] model_mask;
	logic [0:`ERR_WIDTH-1] model_last;
	logic [0:`ERR_WIDTH-1] model_count;
	logic                  model_enable;
	int                    model_credits = `RESP_CREDITS;

	// Host side bookkeeping
	afu_err_pkg::resp_kind kind_q [$];
	logic [0:`ERR_WIDTH-1] data_q [$];
	int                    pending_returns = 0;
	int                    resp_count = 0;
	bit                    hold_credits = 0;
	int                    seed = 62174;
	int                    checks = 0;
	int                    errors = 0;
	int                    test_errors = 0;
	int                    cycle_count = 0;

	tb_clock_gen u_clock_gen (
		.clock (clock),
		.rstn  (rstn)
	);

	afu_err_top u_dut (
		.clock              (clock),
		.rstn               (rstn),
		.cmd_errors         (cmd_errors),
		.rsp_errors         (rsp_errors),
		.buf_errors         (buf_errors),
		.mmio_write         (mmio_write),
		.mmio_read          (mmio_read),
		.mmio_addr          (mmio_addr),
		.mmio_wdata         (mmio_wdata),
		.resp_credit_return (resp_credit_return),
		.resp_valid         (resp_valid),
		.resp_kind          (resp_kind),
		.resp_data          (resp_data)
	);

	// ------------------------------------------------------------------
	// Checking helpers
	// ------------------------------------------------------------------

	task automatic check_value(input string name, input logic [0:`ERR_WIDTH-1] expected,
			input logic [0:`ERR_WIDTH-1] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at %0t: %s expected %h, actual %h", $time, name, expected,
				actual);
		end
	endtask

	task automatic note_failure(input string what);
		errors++;
		$display("Failure at %0t: %s", $time, what);
	endtask

	task automatic finish_test(input int num, input string name);
		$display("Test %0d %s: done with %0d errors", num, name, errors - test_errors);
		test_errors = errors;
	endtask

	function automatic logic [0:`ERR_WIDTH-1] rand64();
		return {$random(seed), $random(seed)};
	endfunction

	// Register contents as the host should see them
	function automatic logic [0:`ERR_WIDTH-1] model_reg(input logic [1:0] addr);
		case (addr)
			`REG_ENABLE:     return {{(`ERR_WIDTH-1){1'b0}}, model_enable};
			`REG_MASK:       return model_mask;
			`REG_LAST_ERROR: return model_last;
			default:         return model_count;
		endcase
	endfunction

	// ------------------------------------------------------------------
	// Host response side
	// ------------------------------------------------------------------

	// Every beat queued and owed a credit
	always @(posedge clock) begin
		if (rstn && resp_valid) begin
			kind_q.push_back(resp_kind);
			data_q.push_back(resp_data);
			resp_count++;
			pending_returns++;
			if (model_credits == 0) begin
				note_failure("response issued with no host credit left");
			end else begin
				model_credits--;
			end
		end
	end

	// One credit back per consumed beat unless held
	initial begin
		resp_credit_return = 1'b0;
		forever begin
			@(negedge clock);
			if (!hold_credits && pending_returns > 0) begin
				resp_credit_return = 1'b1;
				pending_returns--;
				model_credits++;
			end else begin
				resp_credit_return = 1'b0;
			end
		end
	end

	// Hang guard
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout after %0d cycles, the run appears to hang", cycle_count);
			$display("Checks failed");
			$finish;
		end
	end

	// ------------------------------------------------------------------
	// Host request tasks
	// ------------------------------------------------------------------

	task automatic idle(input int cycles);
		repeat (cycles) @(negedge clock);
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [0:`ERR_WIDTH-1] data);
		@(negedge clock);
		mmio_write = 1'b1;
		mmio_addr  = addr;
		mmio_wdata = data;
		@(negedge clock);
		mmio_write = 1'b0;
		if (addr == `REG_ENABLE) begin
			model_enable = data[`ERR_WIDTH-1];
		end else if (addr == `REG_MASK) begin
			model_mask = data;
		end
	endtask

	task automatic issue_read(input logic [1:0] addr);
		@(negedge clock);
		mmio_read = 1'b1;
		mmio_addr = addr;
		@(negedge clock);
		mmio_read = 1'b0;
	endtask

	// One cycle pulse on all three units
	task automatic inject_errors(input logic [0:`ERR_WIDTH-1] cmd,
			input logic [0:`ERR_WIDTH-1] rsp, input logic [0:`ERR_WIDTH-1] bufv);
		@(negedge clock);
		cmd_errors   = cmd;
		rsp_errors   = rsp;
		buf_errors   = bufv;
		model_sticky = model_sticky | ((cmd | rsp | bufv) & model_mask);
		@(negedge clock);
		cmd_errors = '0;
		rsp_errors = '0;
		buf_errors = '0;
	endtask

	task automatic wait_responses(input int n, output bit got);
		int waited;
		waited = 0;
		while (kind_q.size() < n && waited < wait_limit) begin
			@(negedge clock);
			waited++;
		end
		got = (kind_q.size() >= n);
		if (!got) begin
			note_failure($sformatf("expected %0d responses, only %0d arrived", n,
				kind_q.size()));
		end
	endtask

	task automatic take_response(output afu_err_pkg::resp_kind kind,
			output logic [0:`ERR_WIDTH-1] data, output bit got);
		wait_responses(1, got);
		kind = afu_err_pkg::RESP_ERROR_NOTIFY;
		data = '0;
		if (got) begin
			kind = kind_q.pop_front();
			data = data_q.pop_front();
		end
	endtask

	task automatic check_quiet();
		if (kind_q.size() != 0) begin
			note_failure($sformatf("%0d unexpected responses on the host bus",
				kind_q.size()));
			kind_q.delete();
			data_q.delete();
		end
	endtask

	// Notify payload is the masked sticky set, which then clears
	task automatic check_notify_data(input logic [0:`ERR_WIDTH-1] data);
		check_value("resp_data", model_sticky, data);
		check_value("resp_data masked bits", '0, data & ~model_mask);
		model_last   = model_sticky;
		model_count  = model_count + 1'b1;
		model_sticky = '0;
	endtask

	task automatic expect_notify();
		afu_err_pkg::resp_kind kind;
		logic [0:`ERR_WIDTH-1] data;
		bit                    got;
		take_response(kind, data, got);
		if (got) begin
			check_value("resp_kind", 64'(afu_err_pkg::RESP_ERROR_NOTIFY), 64'(kind));
			check_notify_data(data);
		end
	endtask

	task automatic read_and_check(input logic [1:0] addr);
		afu_err_pkg::resp_kind kind;
		logic [0:`ERR_WIDTH-1] data;
		logic [0:`ERR_WIDTH-1] expected;
		bit                    got;
		expected = model_reg(addr);
		issue_read(addr);
		take_response(kind, data, got);
		if (got) begin
			check_value("resp_kind", 64'(afu_err_pkg::RESP_READ_DATA), 64'(kind));
			check_value("resp_data", expected, data);
		end
		idle(3);
		check_quiet();
	endtask

	// One notify plus one read in either order
	task automatic collect_pair(input logic [0:`ERR_WIDTH-1] read_expected);
		afu_err_pkg::resp_kind kind;
		logic [0:`ERR_WIDTH-1] data;
		bit                    got;
		int                    notifies;
		int                    reads;
		notifies = 0;
		reads    = 0;
		wait_responses(2, got);
		while (kind_q.size() > 0) begin
			kind = kind_q.pop_front();
			data = data_q.pop_front();
			if (kind == afu_err_pkg::RESP_ERROR_NOTIFY) begin
				notifies++;
				check_notify_data(data);
			end else begin
				reads++;
				check_value("resp_data", read_expected, data);
			end
		end
		if (got && (notifies != 1 || reads != 1)) begin
			note_failure($sformatf("got %0d notifications and %0d read responses, wanted one each",
				notifies, reads));
		end
		idle(10);
		check_quiet();
	endtask

	// ------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------

	initial begin
		logic [1:0]            addr;
		logic [0:`ERR_WIDTH-1] expected;
		int                    hold_start;
		cmd_errors   = '0;
		rsp_errors   = '0;
		buf_errors   = '0;
		mmio_write   = 1'b0;
		mmio_read    = 1'b0;
		mmio_addr    = '0;
		mmio_wdata   = '0;
		model_sticky = '0;
		model_mask   = '1;
		model_last   = '0;
		model_count  = '0;
		model_enable = 1'b0;
		wait (rstn === 1'b1);
		idle(2);

		// Register access, no errors in flight
		for (int i = 0; i < 6; i++) begin
			if (i % 2 == 0) begin
				write_reg(`REG_ENABLE, rand64());
			end else begin
				write_reg(`REG_MASK, rand64());
			end
			read_and_check(`REG_ENABLE);
			read_and_check(`REG_MASK);
		end
		read_and_check(`REG_LAST_ERROR);
		read_and_check(`REG_REPORT_COUNT);
		finish_test(1, "register access");

		// Plain notifications
		write_reg(`REG_ENABLE, 64'd1);
		write_reg(`REG_MASK, rand64());
		idle(2);
		for (int i = 0; i < 4; i++) begin
			inject_errors(rand64(), rand64(), rand64());
			expect_notify();
			idle(6);
			read_and_check(`REG_REPORT_COUNT);
			read_and_check(`REG_LAST_ERROR);
		end
		finish_test(2, "notification");

		// Sparse masks, reported bits must not come back
		for (int i = 0; i < 4; i++) begin
			write_reg(`REG_MASK, rand64() & rand64());
			idle(2);
			inject_errors(rand64(), rand64(), rand64());
			expect_notify();
			idle(20);
			check_quiet();
			read_and_check(`REG_REPORT_COUNT);
		end
		finish_test(3, "masking and clearing");

		// Errors pile up while disabled
		write_reg(`REG_ENABLE, 64'd0);
		write_reg(`REG_MASK, rand64());
		idle(3);
		for (int i = 0; i < 3; i++) begin
			inject_errors(rand64(), rand64() & rand64(), '0);
			idle(2);
		end
		idle(20);
		check_quiet();
		read_and_check(`REG_REPORT_COUNT);
		write_reg(`REG_ENABLE, 64'd1);
		expect_notify();
		idle(20);
		check_quiet();
		read_and_check(`REG_REPORT_COUNT);
		finish_test(4, "enable gating");

		// Drain all credits, then queue a notify and a read
		idle(4);
		@(posedge clock);
		hold_credits = 1'b1;
		hold_start   = resp_count;
		for (int i = 0; i < `RESP_CREDITS; i++) begin
			addr = 2'($random(seed));
			read_and_check(addr);
		end
		addr     = `REG_LAST_ERROR;
		expected = model_reg(addr);
		inject_errors(rand64(), '0, rand64());
		issue_read(addr);
		idle(25);
		check_quiet();
		if (resp_count - hold_start > `RESP_CREDITS) begin
			note_failure("more responses than credits while credits were held");
		end
		@(posedge clock);
		hold_credits = 1'b0;
		collect_pair(expected);
		finish_test(5, "credit back-pressure");

		// Read with the errors, or one cycle later so both requests meet
		for (int i = 0; i < 4; i++) begin
			addr     = (i % 2 == 0) ? `REG_REPORT_COUNT : `REG_LAST_ERROR;
			expected = model_reg(addr);
			@(negedge clock);
			cmd_errors   = rand64();
			rsp_errors   = rand64();
			buf_errors   = '0;
			mmio_read    = (i % 2 == 1);
			mmio_addr    = addr;
			model_sticky = model_sticky | ((cmd_errors | rsp_errors) & model_mask);
			@(negedge clock);
			cmd_errors = '0;
			rsp_errors = '0;
			mmio_read  = (i % 2 == 0);
			@(negedge clock);
			mmio_read  = 1'b0;
			collect_pair(expected);
		end
		finish_test(6, "contention");

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== test/afu_err_assertions.sv ====
`timescale 1ns/1ps
`include "afu_err_consts.svh"

module afu_err_assertions #(
	parameter bit check_arbiter = 1'b1
) (
	input logic                     clock,
	input logic                     rstn,
	input logic [`CREDIT_WIDTH-1:0] credits,
	input logic                     error_ack,
	input logic                     read_ack,
	input logic                     reset_error
);

	if (check_arbiter) begin : g_arbiter

		// Credit counter stays within the host allowance
		credit_bound: assert property (@(posedge clock) disable iff (!rstn)
			credits <= `RESP_CREDITS)
			else $error("credit count above the host allowance");

		// Nothing granted on an empty credit counter
		no_grant_without_credit: assert property (@(posedge clock) disable iff (!rstn)
			(credits == '0) |-> !(error_ack || read_ack))
			else $error("grant given with zero credits");

		// One winner per cycle
		single_grant: assert property (@(posedge clock) disable iff (!rstn)
			!(error_ack && read_ack))
			else $error("both requesters acked in one cycle");

	end else begin : g_control

		// Clear pulse lasts one cycle
		clear_pulse_width: assert property (@(posedge clock) disable iff (!rstn)
			!reset_error |=> reset_error)
			else $error("reset_error low for two cycles in a row");

	end

endmodule

// Arbiter side, credits and grants
bind mmio_resp_arbiter afu_err_assertions #(.check_arbiter(1'b1)) u_arbiter_checks (
	.clock       (clock),
	.rstn        (rstn),
	.credits     (credits),
	.error_ack   (report_errors_ack),
	.read_ack    (read_ack),
	.reset_error (1'b1)
);

// FSM side, clear pulse only
bind error_control afu_err_assertions #(.check_arbiter(1'b0)) u_control_checks (
	.clock       (clock),
	.rstn        (rstn),
	.credits     ({`CREDIT_WIDTH{1'b0}}),
	.error_ack   (1'b0),
	.read_ack    (1'b0),
	.reset_error (reset_error)
);

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int half_period  = 4,
	parameter int reset_cycles = 5
) (
	output logic clock,
	output logic rstn
);

	// Free running 8 ns clock
	initial begin
		clock = 1'b0;
		forever #half_period clock = ~clock;
	end

	// Reset held for the first cycles, released away from the rising edge
	initial begin
		rstn = 1'b0;
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
	end

endmodule

// ==== logic/afu_err_top.sv ====
`timescale 1ns/1ps
`include "afu_err_consts.svh"

module afu_err_top (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic [0:`ERR_WIDTH-1] cmd_errors,
	input  logic [0:`ERR_WIDTH-1] rsp_errors,
	input  logic [0:`ERR_WIDTH-1] buf_errors,
	input  logic                  mmio_write,
	input  logic                  mmio_read,
	input  logic [1:0]            mmio_addr,
	input  logic [0:`ERR_WIDTH-1] mmio_wdata,
	input  logic                  resp_credit_return,
	output logic                  resp_valid,
	output afu_err_pkg::resp_kind resp_kind,
	output logic [0:`ERR_WIDTH-1] resp_data
);

	// Register block to error path
	logic [0:`ERR_WIDTH-1] error_mask;
	logic                  enabled_in;
	// Collector and FSM handshake
	logic [0:`ERR_WIDTH-1] external_errors;
	logic [0:`ERR_WIDTH-1] report_errors;
	logic                  reset_error;
	// Arbiter requesters
	logic                  report_req;
	logic                  report_errors_ack;
	logic                  read_req;
	logic                  read_ack;
	logic [0:`ERR_WIDTH-1] read_data;

	error_collector u_collector (
		.clock           (clock),
		.rstn            (rstn),
		.cmd_errors      (cmd_errors),
		.rsp_errors      (rsp_errors),
		.buf_errors      (buf_errors),
		.error_mask      (error_mask),
		.report_errors   (report_errors),
		.reset_error     (reset_error),
		.external_errors (external_errors)
	);

	error_control u_control (
		.clock             (clock),
		.rstn              (rstn),
		.enabled_in        (enabled_in),
		.external_errors   (external_errors),
		.report_errors_ack (report_errors_ack),
		.report_req        (report_req),
		.reset_error       (reset_error),
		.report_errors     (report_errors)
	);

	mmio_regs u_regs (
		.clock             (clock),
		.rstn              (rstn),
		.mmio_write        (mmio_write),
		.mmio_read         (mmio_read),
		.mmio_addr         (mmio_addr),
		.mmio_wdata        (mmio_wdata),
		.report_errors     (report_errors),
		.report_errors_ack (report_errors_ack),
		.read_ack          (read_ack),
		.enabled_in        (enabled_in),
		.error_mask        (error_mask),
		.read_req          (read_req),
		.read_data         (read_data)
	);

	// Shared host response bus
	mmio_resp_arbiter u_arbiter (
		.clock              (clock),
		.rstn               (rstn),
		.report_req         (report_req),
		.report_errors      (report_errors),
		.read_req           (read_req),
		.read_data          (read_data),
		.resp_credit_return (resp_credit_return),
		.report_errors_ack  (report_errors_ack),
		.read_ack           (read_ack),
		.resp_valid         (resp_valid),
		.resp_kind          (resp_kind),
		.resp_data          (resp_data)
	);

endmodule

// ==== logic/mmio_resp_arbiter.sv ====
`timescale 1ns/1ps
`include "afu_err_consts.svh"

module mmio_resp_arbiter (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  report_req,
	input  logic [0:`ERR_WIDTH-1] report_errors,
	input  logic                  read_req,
	input  logic [0:`ERR_WIDTH-1] read_data,
	input  logic                  resp_credit_return,
	output logic                  report_errors_ack,
	output logic                  read_ack,
	output logic                  resp_valid,
	output afu_err_pkg::resp_kind resp_kind,
	output logic [0:`ERR_WIDTH-1] resp_data
);

	logic [`CREDIT_WIDTH-1:0] credits;
	logic                     has_credit;
	logic                     error_first;
	logic                     grant_error;
	logic                     grant_read;
	logic                     grant_any;

	// ------------------------------------------------------------------
	// Grant
	// ------------------------------------------------------------------

	assign has_credit = (credits != '0);

	// Error side wins on its turn or when read is idle
	assign grant_error = has_credit && report_req && (error_first || !read_req);
	assign grant_read  = has_credit && read_req && !grant_error;
	assign grant_any   = grant_error || grant_read;

	assign report_errors_ack = grant_error;
	assign read_ack          = grant_read;

	// Round-robin turn, error peer first
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			error_first <= 1'b1;
		end else if (grant_error) begin
			error_first <= 1'b0;
		end else if (grant_read) begin
			error_first <= 1'b1;
		end
	end

	// ------------------------------------------------------------------
	// Credits
	// ------------------------------------------------------------------

	// Send plus return in one cycle nets to zero
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			credits <= `CREDIT_WIDTH'(`RESP_CREDITS);
		end else begin
			case ({grant_any, resp_credit_return})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: ;
			endcase
		end
	end

	// ------------------------------------------------------------------
	// Response bus
	// ------------------------------------------------------------------

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= grant_any;
		end
	end

	// Winner's kind and payload onto the bus
	always_ff @(posedge clock) begin
		if (grant_error) begin
			resp_kind <= afu_err_pkg::RESP_ERROR_NOTIFY;
			resp_data <= report_errors;
		end else if (grant_read) begin
			resp_kind <= afu_err_pkg::RESP_READ_DATA;
			resp_data <= read_data;
		end
	end

endmodule

// ==== logic/mmio_regs.sv ====
`timescale 1ns/1ps
`include "afu_err_consts.svh"

module mmio_regs (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  mmio_write,
	input  logic                  mmio_read,
	input  logic [1:0]            mmio_addr,
	input  logic [0:`ERR_WIDTH-1] mmio_wdata,
	input  logic [0:`ERR_WIDTH-1] report_errors,
	input  logic                  report_errors_ack,
	input  logic                  read_ack,
	output logic                  enabled_in,
	output logic [0:`ERR_WIDTH-1] error_mask,
	output logic                  read_req,
	output logic [0:`ERR_WIDTH-1] read_data
);

	logic [0:`ERR_WIDTH-1] last_error;
	logic [0:`ERR_WIDTH-1] report_count;
	logic [0:`ERR_WIDTH-1] selected_reg;

	// ------------------------------------------------------------------
	// Host writable registers
	// ------------------------------------------------------------------

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled_in <= 1'b0;
			error_mask <= '1;
		end else if (mmio_write) begin
			case (mmio_addr)
				// Enable sits in the LSB
				`REG_ENABLE: enabled_in <= mmio_wdata[`ERR_WIDTH-1];
				`REG_MASK:   error_mask <= mmio_wdata;
				default:     ;
			endcase
		end
	end

	// ------------------------------------------------------------------
	// Report status, read only
	// ------------------------------------------------------------------

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_error   <= '0;
			report_count <= '0;
		end else if (report_errors_ack) begin
			last_error   <= report_errors;
			report_count <= report_count + 1'b1;
		end
	end

	// ------------------------------------------------------------------
	// Read path
	// ------------------------------------------------------------------

	// Register select
	always_comb begin
		case (mmio_addr)
			`REG_ENABLE:       selected_reg = {{(`ERR_WIDTH-1){1'b0}}, enabled_in};
			`REG_MASK:         selected_reg = error_mask;
			`REG_LAST_ERROR:   selected_reg = last_error;
			`REG_REPORT_COUNT: selected_reg = report_count;
			default:           selected_reg = '0;
		endcase
	end

	// Request held until the arbiter takes it
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_req <= 1'b0;
		end else if (read_ack) begin
			read_req <= 1'b0;
		end else if (mmio_read) begin
			read_req <= 1'b1;
		end
	end

	// Read value frozen at request time
	always_ff @(posedge clock) begin
		if (mmio_read) begin
			read_data <= selected_reg;
		end
	end

endmodule

// ==== logic/error_control.sv ====
`timescale 1ns/1ps
`include "afu_err_consts.svh"

module error_control (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enabled_in,
	input  logic [0:`ERR_WIDTH-1] external_errors,
	input  logic                  report_errors_ack,
	output logic                  report_req,
	output logic                  reset_error,
	output logic [0:`ERR_WIDTH-1] report_errors
);

	afu_err_pkg::error_state current_state;
	afu_err_pkg::error_state next_state;
	logic                    enabled;
	logic                    error_flag;

	// Any pending error at all
	assign error_flag = |external_errors;

	// ------------------------------------------------------------------
	// Enable from host, one cycle late
	// ------------------------------------------------------------------

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	// ------------------------------------------------------------------
	// Report FSM
	// ------------------------------------------------------------------

	// Frozen while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			current_state <= afu_err_pkg::RESET;
		end else if (enabled) begin
			current_state <= next_state;
		end
	end

	always_comb begin
		next_state = current_state;
		case (current_state)
			afu_err_pkg::RESET:         next_state = afu_err_pkg::IDLE;
			afu_err_pkg::IDLE:          if (error_flag) next_state = afu_err_pkg::MMIO_REQ;
			afu_err_pkg::MMIO_REQ:      if (report_errors_ack) next_state = afu_err_pkg::RESET_REQ;
			afu_err_pkg::RESET_REQ:     next_state = afu_err_pkg::RESET_PENDING;
			afu_err_pkg::RESET_PENDING: next_state = afu_err_pkg::IDLE;
			default:                    next_state = afu_err_pkg::RESET;
		endcase
	end

	// Registered outputs
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			report_req    <= 1'b0;
			reset_error   <= 1'b1;
			report_errors <= '0;
		end else if (enabled) begin
			// High together with the MMIO_REQ state
			report_req <= (next_state == afu_err_pkg::MMIO_REQ);
			case (current_state)
				afu_err_pkg::RESET: begin
					report_errors <= '0;
					reset_error   <= 1'b1;
				end
				afu_err_pkg::IDLE: begin
					// Snapshot follows the collector until a report starts
					report_errors <= external_errors;
					reset_error   <= 1'b1;
				end
				afu_err_pkg::RESET_REQ: begin
					reset_error <= 1'b0;
				end
				default: begin
					reset_error <= 1'b1;
				end
			endcase
		end
	end

endmodule

// ==== logic/error_collector.sv ====
`timescale 1ns/1ps
`include "afu_err_consts.svh"

module error_collector (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic [0:`ERR_WIDTH-1] cmd_errors,
	input  logic [0:`ERR_WIDTH-1] rsp_errors,
	input  logic [0:`ERR_WIDTH-1] buf_errors,
	input  logic [0:`ERR_WIDTH-1] error_mask,
	input  logic [0:`ERR_WIDTH-1] report_errors,
	input  logic                  reset_error,
	output logic [0:`ERR_WIDTH-1] external_errors
);

	logic [0:`ERR_WIDTH-1] unit_errors [`NUM_ERR_UNITS];
	logic [0:`ERR_WIDTH-1] combined_errors;
	logic [0:`ERR_WIDTH-1] new_errors;

	// One vector per unit
	assign unit_errors[0] = cmd_errors;
	assign unit_errors[1] = rsp_errors;
	assign unit_errors[2] = buf_errors;

	// OR across all units
	always_comb begin
		combined_errors = '0;
		for (int i = 0; i < `NUM_ERR_UNITS; i++) begin
			combined_errors = combined_errors | unit_errors[i];
		end
	end

	// Masked bits never enter the sticky set
	assign new_errors = combined_errors & error_mask;

	// Sticky bits, cleared only for what was reported
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			external_errors <= '0;
		end else if (!reset_error) begin
			// A reported bit raised again right now is lost
			external_errors <= (external_errors | new_errors) & ~report_errors;
		end else begin
			external_errors <= external_errors | new_errors;
		end
	end

endmodule

// ==== logic/afu_err_pkg.sv ====
package afu_err_pkg;

	// ------------------------------------------------------------------
	// Error reporting state machine
	// ------------------------------------------------------------------

	// Walk of one report: snapshot, notify, clear
	typedef enum logic [2:0] {
		RESET,
		IDLE,
		MMIO_REQ,
		RESET_REQ,
		RESET_PENDING
	} error_state;

	// ------------------------------------------------------------------
	// Host response bus
	// ------------------------------------------------------------------

	// What a response beat carries
	typedef enum logic {
		RESP_ERROR_NOTIFY,
		RESP_READ_DATA
	} resp_kind;

endpackage

// ==== logic/afu_err_consts.svh ====
`ifndef AFU_ERR_CONSTS_SVH
`define AFU_ERR_CONSTS_SVH

// Error vector width, bit 0 is the MSB
`define ERR_WIDTH 64

// Error sources feeding the collector
`define NUM_ERR_UNITS 3

// MMIO register map
`define REG_ENABLE       2'd0
`define REG_MASK         2'd1
`define REG_LAST_ERROR   2'd2
`define REG_REPORT_COUNT 2'd3

// Host response credits
`define RESP_CREDITS 4
`define CREDIT_WIDTH 3

`endif
